// ==== verilog/ibuf_pkg.sv ====
`default_nettype none

package ibuf_pkg;

    // default line width, 16 bytes per fetch line
    localparam int LINE_W = 128;

    // one fetched cache line
    typedef logic [LINE_W-1:0] line_t;

    // two slots per bank, even and odd banks interleaved
    localparam int NUM_SLOTS  = 4;
    localparam int SLOT_IDX_W = 2;

    typedef logic [SLOT_IDX_W-1:0] slot_idx_t;

    // byte offset inside a line
    localparam int OFFSET_W = 4;

    // buffer instruction pointer with the slot index above the byte offset
    typedef struct packed {
        slot_idx_t           slot;
        logic [OFFSET_W-1:0] offset;
    } bip_t;

    // one bit per slot, indexed by slot number
    typedef logic [NUM_SLOTS-1:0] slot_vec_t;

    // slot names, bit 0 of the index is the bank (0 even, 1 odd)
    localparam slot_idx_t SLOT_00 = 2'b00;
    localparam slot_idx_t SLOT_01 = 2'b01;
    localparam slot_idx_t SLOT_10 = 2'b10;
    localparam slot_idx_t SLOT_11 = 2'b11;

endpackage

`default_nettype wire

// ==== verilog/fetch_bank_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface fetch_bank_if #(
    parameter int LINE_W = $bits(ibuf_pkg::line_t)
);
    import ibuf_pkg::*;

    // line coming out of this fetch bank
    logic [LINE_W-1:0] line;

    // low bits of the fetch pointer, picks the target slot
    slot_idx_t slot_sel;

    // cache miss on this bank
    logic miss;

    // fetch stage wait, holds the bank like a miss
    logic stall;

    // driven from the top level ports
    modport src (output line, output slot_sel, output miss, output stall);

    // control reads the slot bits and hold signals, banks read the line
    modport dst (input line, input slot_sel, input miss, input stall);

endinterface

`default_nettype wire

// ==== verilog/slot_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module slot_control (
    input  logic                is_init_i,
    input  logic                is_resteer_i,
    input  logic                is_br_i,
    fetch_bank_if.dst           even_i,
    fetch_bank_if.dst           odd_i,
    input  ibuf_pkg::bip_t      new_bip_i,
    input  ibuf_pkg::bip_t      old_bip_i,
    input  ibuf_pkg::slot_vec_t valid_i,
    output ibuf_pkg::slot_vec_t load_o,
    output ibuf_pkg::slot_vec_t inval_o,
    output logic                even_loaded_o,
    output logic                odd_loaded_o
);
    import ibuf_pkg::*;

    // slots that may take each bank's line
    localparam slot_vec_t EVEN_SLOTS = slot_vec_t'((1 << SLOT_00) | (1 << SLOT_10));
    localparam slot_vec_t ODD_SLOTS  = slot_vec_t'((1 << SLOT_01) | (1 << SLOT_11));

    // control flow change, any flush source
    logic cf;

    // decoded fetch position per bank, masked to that bank's parity
    slot_vec_t even_hit;
    slot_vec_t odd_hit;

    // bank has neither a miss nor a wait
    logic even_go;
    logic odd_go;

    // slots asked for by a fetch that is free to deliver
    slot_vec_t want;
    slot_vec_t load_vec;

    // bip wrapped back inside a line
    logic wrap;
    slot_vec_t wrap_vec;
    slot_vec_t inval_vec;

    // one-hot slot decode
    function automatic slot_vec_t decode_slot(input slot_idx_t idx);
        slot_vec_t vec;
        vec = '0;
        vec[idx] = 1'b1;
        return vec;
    endfunction

    // init, resteer and branch all discard the buffered lines
    assign cf = is_init_i | is_resteer_i | is_br_i;

    // an even fetch pointing at an odd slot selects nothing
    assign even_hit = decode_slot(even_i.slot_sel) & EVEN_SLOTS;
    assign odd_hit  = decode_slot(odd_i.slot_sel) & ODD_SLOTS;

    // miss or wait holds the bank, upstream presents the line again
    assign even_go = ~even_i.miss & ~even_i.stall;
    assign odd_go  = ~odd_i.miss & ~odd_i.stall;

    always_comb begin
        want = '0;
        if (even_go) begin
            want = want | even_hit;
        end
        if (odd_go) begin
            want = want | odd_hit;
        end
    end

    // only empty slots load, so an occupied slot keeps its line
    always_comb begin
        if (cf) begin
            // nothing loads in the flush cycle
            load_vec = '0;
        end else begin
            load_vec = want & ~valid_i;
        end
    end

    assign load_o = load_vec;

    // per bank loaded flags, same cycle as the load decision
    assign even_loaded_o = |(load_vec & EVEN_SLOTS);
    assign odd_loaded_o  = |(load_vec & ODD_SLOTS);

    // smaller new offset means the pointer left the old line
    assign wrap = new_bip_i.offset < old_bip_i.offset;

    always_comb begin
        wrap_vec = '0;
        if (wrap) begin
            // drop only the line the old pointer sat in
            wrap_vec = decode_slot(old_bip_i.slot);
        end
    end

    always_comb begin
        if (cf) begin
            inval_vec = '1;
        end else begin
            inval_vec = wrap_vec;
        end
    end

    // only valid slots get invalidated
    // keeps load and invalidate of one slot exclusive
    assign inval_o = inval_vec & valid_i;

endmodule

`default_nettype wire

// ==== verilog/line_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_bank #(
    parameter int LINE_W = ibuf_pkg::LINE_W
) (
    input  logic              clk,
    input  logic              reset_i,
    fetch_bank_if.dst         fetch_i,
    input  logic [1:0]        load_i,
    input  logic [1:0]        inval_i,
    output logic [LINE_W-1:0] line_0_o,
    output logic [LINE_W-1:0] line_1_o,
    output logic [1:0]        valid_o
);

    // slots held by one bank
    localparam int BANK_SLOTS = 2;

    // line storage, one register per bank-local slot
    logic [LINE_W-1:0] line_q [BANK_SLOTS];

    // slot holds a usable line
    logic [BANK_SLOTS-1:0] valid_q;

    // both slots share the bank's fetch line
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int s = 0; s < BANK_SLOTS; s++) begin
                line_q[s] <= '0;
            end
        end else begin
            for (int s = 0; s < BANK_SLOTS; s++) begin
                if (load_i[s]) begin
                    line_q[s] <= fetch_i.line;
                end
            end
        end
    end

    // invalidate leaves the line data in place
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else begin
            for (int s = 0; s < BANK_SLOTS; s++) begin
                if (inval_i[s]) begin
                    valid_q[s] <= 1'b0;
                end else if (load_i[s]) begin
                    valid_q[s] <= 1'b1;
                end
            end
        end
    end

    assign line_0_o = line_q[0];
    assign line_1_o = line_q[1];
    assign valid_o  = valid_q;

endmodule

`default_nettype wire

// ==== verilog/ibuf_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ibuf_top #(
    parameter int LINE_W = ibuf_pkg::LINE_W
) (
    input  logic                clk,
    input  logic                reset_i,

    // flush sources
    input  logic                is_init_i,
    input  logic                is_resteer_i,
    input  logic                is_br_i,

    // fetched lines
    input  ibuf_pkg::line_t     line_even_i,
    input  ibuf_pkg::line_t     line_odd_i,

    // fetch position low bits per bank
    input  ibuf_pkg::slot_idx_t fip_even_i,
    input  ibuf_pkg::slot_idx_t fip_odd_i,

    // hold conditions per bank
    input  logic                miss_even_i,
    input  logic                miss_odd_i,
    input  logic                wait_even_i,
    input  logic                wait_odd_i,

    // buffer pointer before and after this cycle's advance
    input  ibuf_pkg::bip_t      new_bip_i,
    input  ibuf_pkg::bip_t      old_bip_i,

    output logic [LINE_W-1:0]   line_00_o,
    output logic [LINE_W-1:0]   line_01_o,
    output logic [LINE_W-1:0]   line_10_o,
    output logic [LINE_W-1:0]   line_11_o,
    output ibuf_pkg::slot_vec_t valid_o,
    output logic                even_loaded_o,
    output logic                odd_loaded_o
);
    import ibuf_pkg::*;

    // per-slot control, indexed by slot number
    slot_vec_t slot_load;
    slot_vec_t slot_inval;
    slot_vec_t slot_valid;

    // bank-local views, bit 0 is the low slot of the bank
    logic [1:0] even_load;
    logic [1:0] even_inval;
    logic [1:0] even_valid;
    logic [1:0] odd_load;
    logic [1:0] odd_inval;
    logic [1:0] odd_valid;

    fetch_bank_if #(.LINE_W(LINE_W)) even_bank ();
    fetch_bank_if #(.LINE_W(LINE_W)) odd_bank ();

    // even fetch bank
    assign even_bank.line     = LINE_W'(line_even_i);
    assign even_bank.slot_sel = fip_even_i;
    assign even_bank.miss     = miss_even_i;
    assign even_bank.stall    = wait_even_i;

    // odd fetch bank
    assign odd_bank.line     = LINE_W'(line_odd_i);
    assign odd_bank.slot_sel = fip_odd_i;
    assign odd_bank.miss     = miss_odd_i;
    assign odd_bank.stall    = wait_odd_i;

    slot_control u_slot_control (
        .is_init_i     (is_init_i),
        .is_resteer_i  (is_resteer_i),
        .is_br_i       (is_br_i),
        .even_i        (even_bank),
        .odd_i         (odd_bank),
        .new_bip_i     (new_bip_i),
        .old_bip_i     (old_bip_i),
        .valid_i       (slot_valid),
        .load_o        (slot_load),
        .inval_o       (slot_inval),
        .even_loaded_o (even_loaded_o),
        .odd_loaded_o  (odd_loaded_o)
    );

    // even bank holds slots 00 and 10
    assign even_load  = {slot_load[SLOT_10], slot_load[SLOT_00]};
    assign even_inval = {slot_inval[SLOT_10], slot_inval[SLOT_00]};

    // odd bank holds slots 01 and 11
    assign odd_load  = {slot_load[SLOT_11], slot_load[SLOT_01]};
    assign odd_inval = {slot_inval[SLOT_11], slot_inval[SLOT_01]};

    line_bank #(.LINE_W(LINE_W)) u_even_bank (
        .clk      (clk),
        .reset_i  (reset_i),
        .fetch_i  (even_bank),
        .load_i   (even_load),
        .inval_i  (even_inval),
        .line_0_o (line_00_o),
        .line_1_o (line_10_o),
        .valid_o  (even_valid)
    );

    line_bank #(.LINE_W(LINE_W)) u_odd_bank (
        .clk      (clk),
        .reset_i  (reset_i),
        .fetch_i  (odd_bank),
        .load_i   (odd_load),
        .inval_i  (odd_inval),
        .line_0_o (line_01_o),
        .line_1_o (line_11_o),
        .valid_o  (odd_valid)
    );

    // back to slot order for control and the valid output
    assign slot_valid[SLOT_00] = even_valid[0];
    assign slot_valid[SLOT_10] = even_valid[1];
    assign slot_valid[SLOT_01] = odd_valid[0];
    assign slot_valid[SLOT_11] = odd_valid[1];

    assign valid_o = slot_valid;

endmodule

`default_nettype wire

// ==== verification/ibuf_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module ibuf_checker (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                is_init_i,
    input  logic                is_resteer_i,
    input  logic                is_br_i,
    input  ibuf_pkg::slot_vec_t load_i,
    input  ibuf_pkg::slot_vec_t inval_i,
    input  ibuf_pkg::slot_vec_t valid_i
);
    import ibuf_pkg::*;

    // any control flow change
    logic flush;

    assign flush = is_init_i | is_resteer_i | is_br_i;

    // a slot is either filled or dropped, never both in one cycle
    load_inval_excl: assert property (@(posedge clk) disable iff (reset_i)
        (load_i & inval_i) == '0)
        else $error("slot loaded and invalidated in the same cycle");

    // one cycle from load to valid, per slot
    for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_slot
        load_sets_valid: assert property (@(posedge clk) disable iff (reset_i)
            load_i[s] |=> valid_i[s])
            else $error("slot %0d not valid one cycle after its load", s);
    end

    // flush empties the whole buffer
    flush_clears_valid: assert property (@(posedge clk) disable iff (reset_i)
        flush |=> (valid_i == '0))
        else $error("valid bits still set one cycle after a flush");

endmodule

`default_nettype wire

// ==== verification/ibuf_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ibuf_tb;
    import ibuf_pkg::*;

    // cycles allowed for reset to clear the valid bits
    localparam int RESET_TIMEOUT = 8;

    logic      clk;
    logic      reset_i;
    logic      is_init;
    logic      is_resteer;
    logic      is_br;
    line_t     line_even;
    line_t     line_odd;
    slot_idx_t fip_even;
    slot_idx_t fip_odd;
    logic      miss_even;
    logic      miss_odd;
    logic      wait_even;
    logic      wait_odd;
    bip_t      new_bip;
    bip_t      old_bip;
    line_t     line_00;
    line_t     line_01;
    line_t     line_10;
    line_t     line_11;
    slot_vec_t valid;
    logic      even_loaded;
    logic      odd_loaded;

    // reference model state as it should be after the last edge
    slot_vec_t model_valid;
    line_t     model_line [NUM_SLOTS];

    integer seed;

    ibuf_top #(.LINE_W(LINE_W)) i_ibuf_top (
        .clk           (clk),
        .reset_i       (reset_i),
        .is_init_i     (is_init),
        .is_resteer_i  (is_resteer),
        .is_br_i       (is_br),
        .line_even_i   (line_even),
        .line_odd_i    (line_odd),
        .fip_even_i    (fip_even),
        .fip_odd_i     (fip_odd),
        .miss_even_i   (miss_even),
        .miss_odd_i    (miss_odd),
        .wait_even_i   (wait_even),
        .wait_odd_i    (wait_odd),
        .new_bip_i     (new_bip),
        .old_bip_i     (old_bip),
        .line_00_o     (line_00),
        .line_01_o     (line_01),
        .line_10_o     (line_10),
        .line_11_o     (line_11),
        .valid_o       (valid),
        .even_loaded_o (even_loaded),
        .odd_loaded_o  (odd_loaded)
    );

    // assertions on the internal slot control vectors
    bind ibuf_top ibuf_checker u_ibuf_checker (
        .clk          (clk),
        .reset_i      (reset_i),
        .is_init_i    (is_init_i),
        .is_resteer_i (is_resteer_i),
        .is_br_i      (is_br_i),
        .load_i       (slot_load),
        .inval_i      (slot_inval),
        .valid_i      (slot_valid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic stop_sim(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic value_fail(input string test, input string sig, input line_t exp,
                              input line_t act);
        stop_sim($sformatf("Fail %s %s: expected %0h, actual %0h", test, sig, exp, act));
    endtask

    task automatic check_value(input string test, input string sig, input line_t exp,
                               input line_t act);
        assert (act === exp) else value_fail(test, sig, exp, act);
    endtask

    // line of random words from the seeded generator
    function automatic line_t rand_line();
        line_t l;
        l = '0;
        for (int w = 0; w < LINE_W / 32; w++) begin
            l[w*32 +: 32] = $random(seed);
        end
        return l;
    endfunction

    function automatic bip_t make_bip(input slot_idx_t slot, input logic [OFFSET_W-1:0] offset);
        bip_t b;
        b.slot   = slot;
        b.offset = offset;
        return b;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
    endtask

    task automatic drive_fetch(input line_t le, input slot_idx_t fe, input logic me,
                               input logic we, input line_t lo, input slot_idx_t fo,
                               input logic mo, input logic wo);
        line_even <= le;
        fip_even  <= fe;
        miss_even <= me;
        wait_even <= we;
        line_odd  <= lo;
        fip_odd   <= fo;
        miss_odd  <= mo;
        wait_odd  <= wo;
    endtask

    // both banks waiting so nothing can load
    task automatic drive_hold();
        miss_even <= 1'b0;
        miss_odd  <= 1'b0;
        wait_even <= 1'b1;
        wait_odd  <= 1'b1;
    endtask

    task automatic drive_bip(input bip_t nb, input bip_t ob);
        new_bip <= nb;
        old_bip <= ob;
    endtask

    task automatic drive_flush(input logic init, input logic resteer, input logic br);
        is_init    <= init;
        is_resteer <= resteer;
        is_br      <= br;
    endtask

    // compare outputs with the model at the falling edge, then predict the next edge
    task automatic step(input string test);
        slot_vec_t exp_load;
        slot_vec_t exp_inval;
        logic      cf;
        logic      wrap;
        logic      hold;
        slot_idx_t sel;
        line_t     dut_line [NUM_SLOTS];
        @(negedge clk);
        dut_line[SLOT_00] = line_00;
        dut_line[SLOT_01] = line_01;
        dut_line[SLOT_10] = line_10;
        dut_line[SLOT_11] = line_11;
        check_value(test, "valid_o", line_t'(model_valid), line_t'(valid));
        for (int s = 0; s < NUM_SLOTS; s++) begin
            check_value(test, $sformatf("line_%02b_o", s[1:0]), model_line[s], dut_line[s]);
        end
        cf   = is_init | is_resteer | is_br;
        wrap = new_bip.offset < old_bip.offset;
        exp_load  = '0;
        exp_inval = '0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            // low slot bit names the bank
            if (s[0]) begin
                sel  = fip_odd;
                hold = miss_odd | wait_odd;
            end else begin
                sel  = fip_even;
                hold = miss_even | wait_even;
            end
            exp_load[s]  = !cf && (sel == slot_idx_t'(s)) && !model_valid[s] && !hold;
            exp_inval[s] = model_valid[s] && (cf || (wrap && old_bip.slot == slot_idx_t'(s)));
        end
        check_value(test, "even_loaded_o", line_t'(exp_load[0] | exp_load[2]),
                    line_t'(even_loaded));
        check_value(test, "odd_loaded_o", line_t'(exp_load[1] | exp_load[3]),
                    line_t'(odd_loaded));
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (exp_inval[s]) begin
                model_valid[s] = 1'b0;
            end else if (exp_load[s]) begin
                model_valid[s] = 1'b1;
                model_line[s]  = s[0] ? line_odd : line_even;
            end
        end
    endtask

    task automatic test_reset();
        int cycles;
        cycles = 0;
        // reset is high from time zero
        @(negedge clk);
        while (valid !== '0) begin
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                stop_sim("timeout: valid bits did not clear during reset");
            end
            @(negedge clk);
        end
        next_cycle();
        reset_i <= 1'b0;
        step("reset");
        check_value("reset", "valid_o", '0, line_t'(valid));
    endtask

    task automatic test_parity_fill();
        line_t a;
        line_t b;
        line_t c;
        line_t d;
        a = rand_line();
        b = rand_line();
        c = rand_line();
        d = rand_line();
        next_cycle();
        drive_fetch(a, SLOT_00, 1'b0, 1'b0, b, SLOT_01, 1'b0, 1'b0);
        step("parity_fill");
        check_value("parity_fill", "even_loaded_o", line_t'(1'b1), line_t'(even_loaded));
        check_value("parity_fill", "odd_loaded_o", line_t'(1'b1), line_t'(odd_loaded));
        next_cycle();
        drive_fetch(c, SLOT_10, 1'b0, 1'b0, d, SLOT_11, 1'b0, 1'b0);
        step("parity_fill");
        check_value("parity_fill", "line_00_o", a, line_00);
        check_value("parity_fill", "line_01_o", b, line_01);
        // all four lines in flight
        next_cycle();
        drive_hold();
        step("parity_fill");
        check_value("parity_fill", "valid_o", line_t'(4'b1111), line_t'(valid));
        check_value("parity_fill", "line_11_o", d, line_11);
    endtask

    task automatic test_stall_miss();
        line_t a;
        line_t b;
        line_t c;
        line_t d;
        a = rand_line();
        b = rand_line();
        c = rand_line();
        d = rand_line();
        // start from an empty buffer
        next_cycle();
        drive_hold();
        drive_flush(1'b1, 1'b0, 1'b0);
        step("stall_miss");
        // even miss lets the odd bank load alone
        next_cycle();
        drive_flush(1'b0, 1'b0, 1'b0);
        drive_fetch(a, SLOT_00, 1'b1, 1'b0, b, SLOT_01, 1'b0, 1'b0);
        step("stall_miss");
        check_value("stall_miss", "even_loaded_o", '0, line_t'(even_loaded));
        check_value("stall_miss", "odd_loaded_o", line_t'(1'b1), line_t'(odd_loaded));
        // odd wait lets the even bank load alone
        next_cycle();
        drive_fetch(c, SLOT_10, 1'b0, 1'b0, d, SLOT_11, 1'b0, 1'b1);
        step("stall_miss");
        check_value("stall_miss", "even_loaded_o", line_t'(1'b1), line_t'(even_loaded));
        check_value("stall_miss", "odd_loaded_o", '0, line_t'(odd_loaded));
        // fetch again into the occupied slots 10 and 01
        next_cycle();
        drive_fetch(rand_line(), SLOT_10, 1'b0, 1'b0, rand_line(), SLOT_01, 1'b0, 1'b0);
        step("stall_miss");
        check_value("stall_miss", "odd_loaded_o", '0, line_t'(odd_loaded));
        // each bank aimed at an empty slot of the other parity selects nothing
        next_cycle();
        drive_fetch(rand_line(), SLOT_11, 1'b0, 1'b0, rand_line(), SLOT_00, 1'b0, 1'b0);
        step("stall_miss");
        check_value("stall_miss", "even_loaded_o", '0, line_t'(even_loaded));
        check_value("stall_miss", "odd_loaded_o", '0, line_t'(odd_loaded));
        next_cycle();
        drive_hold();
        step("stall_miss");
        check_value("stall_miss", "line_10_o", c, line_10);
        check_value("stall_miss", "line_01_o", b, line_01);
        check_value("stall_miss", "valid_o", line_t'(4'b0110), line_t'(valid));
    endtask

    task automatic test_wrap();
        line_t kept;
        // flush, then fill every slot
        next_cycle();
        drive_hold();
        drive_flush(1'b0, 1'b1, 1'b0);
        step("wrap");
        next_cycle();
        drive_flush(1'b0, 1'b0, 1'b0);
        drive_fetch(rand_line(), SLOT_00, 1'b0, 1'b0, rand_line(), SLOT_01, 1'b0, 1'b0);
        step("wrap");
        next_cycle();
        kept = rand_line();
        drive_fetch(kept, SLOT_10, 1'b0, 1'b0, rand_line(), SLOT_11, 1'b0, 1'b0);
        step("wrap");
        // offset 9 to 3 leaves slot 10
        next_cycle();
        drive_hold();
        drive_bip(make_bip(SLOT_11, 4'd3), make_bip(SLOT_10, 4'd9));
        step("wrap");
        // equal offset
        next_cycle();
        drive_bip(make_bip(SLOT_01, 4'd5), make_bip(SLOT_01, 4'd5));
        step("wrap");
        check_value("wrap", "valid_o", line_t'(4'b1011), line_t'(valid));
        // larger offset
        next_cycle();
        drive_bip(make_bip(SLOT_00, 4'd7), make_bip(SLOT_00, 4'd2));
        step("wrap");
        check_value("wrap", "valid_o", line_t'(4'b1011), line_t'(valid));
        next_cycle();
        drive_bip('0, '0);
        step("wrap");
        check_value("wrap", "valid_o", line_t'(4'b1011), line_t'(valid));
        check_value("wrap", "line_10_o", kept, line_10);
    endtask

    task automatic test_flush(input string test, input int kind);
        line_t x;
        line_t y;
        x = rand_line();
        y = rand_line();
        // only slots 00 and 01 hold lines
        next_cycle();
        drive_hold();
        drive_flush(1'b1, 1'b0, 1'b0);
        step(test);
        next_cycle();
        drive_flush(1'b0, 1'b0, 1'b0);
        drive_fetch(rand_line(), SLOT_00, 1'b0, 1'b0, rand_line(), SLOT_01, 1'b0, 1'b0);
        step(test);
        // flush while 10 and 11 are free to load
        next_cycle();
        drive_flush(kind == 0, kind == 1, kind == 2);
        drive_fetch(x, SLOT_10, 1'b0, 1'b0, y, SLOT_11, 1'b0, 1'b0);
        step(test);
        check_value(test, "even_loaded_o", '0, line_t'(even_loaded));
        check_value(test, "odd_loaded_o", '0, line_t'(odd_loaded));
        next_cycle();
        drive_flush(1'b0, 1'b0, 1'b0);
        drive_hold();
        step(test);
        check_value(test, "valid_o", '0, line_t'(valid));
        // refill after the flush
        next_cycle();
        drive_fetch(x, SLOT_10, 1'b0, 1'b0, y, SLOT_11, 1'b0, 1'b0);
        step(test);
        next_cycle();
        drive_hold();
        step(test);
        check_value(test, "valid_o", line_t'(4'b1100), line_t'(valid));
        check_value(test, "line_10_o", x, line_10);
        check_value(test, "line_11_o", y, line_11);
    endtask

    initial begin
        seed       = 62;
        reset_i    = 1'b1;
        is_init    = 1'b0;
        is_resteer = 1'b0;
        is_br      = 1'b0;
        line_even  = '0;
        line_odd   = '0;
        fip_even   = SLOT_00;
        fip_odd    = SLOT_01;
        miss_even  = 1'b0;
        miss_odd   = 1'b0;
        wait_even  = 1'b1;
        wait_odd   = 1'b1;
        new_bip    = '0;
        old_bip    = '0;
        model_valid = '0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            model_line[s] = '0;
        end
        test_reset();
        test_parity_fill();
        test_stall_miss();
        test_wrap();
        test_flush("flush_init", 0);
        test_flush("flush_resteer", 1);
        test_flush("flush_branch", 2);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== ibuf.f ====
verilog/ibuf_pkg.sv
verilog/fetch_bank_if.sv
verilog/slot_control.sv
verilog/line_bank.sv
verilog/ibuf_top.sv
verification/ibuf_checker.sv
verification/ibuf_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the instruction buffer testbench with Verilator
set -e

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f ibuf.f --top-module ibuf_tb -o ibuf_sim

# the simulation exits nonzero on an error, the log search gives the verdict
./obj_dir/ibuf_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation finished: PASS" sim.log; then
    echo "ibuf test run passed"
else
    echo "ibuf test run failed"
    exit 1
fi
